// File: dv/histAccumulator_checker.sv
`timescale 1ns/1ns
`default_nettype none

module histAccumulatorChecker (
    input wire                   clk,
    input wire                   res,
    input wire sifhPkg::binInc_t binInc,
    input wire                   clearReq,
    input wire                   clearing,
    input wire sifhPkg::ramWr_t  ramWr,
    input wire                   clearDone
);
    import sifhPkg::*;

    // mapper holds off while the sweep owns the write port
    noIncDuringClear: assert property (@(posedge clk) disable iff (!res)
        clearing |-> !binInc.valid)
        else $error("increment arrived during the clear sweep");

    clearDoneTiming: assert property (@(posedge clk) disable iff (!res)
        clearReq |-> ##(binNum + 1) clearDone)
        else $error("clearDone late or missing after clearReq");

    // an increment that writes zero has wrapped past the top count
    countSaturates: assert property (@(posedge clk) disable iff (!res)
        ramWr.en && !clearing |-> ramWr.data != '0)
        else $error("increment write wrapped past the saturation value");

endmodule

bind histAccumulator histAccumulatorChecker accChk_i (
    .clk(clk), .res(res), .binInc(binInc), .clearReq(clearReq),
    .clearing(clearing), .ramWr(ramWr), .clearDone(clearDone)
);

`default_nettype wire

// File: dv/sifhStim.txt
// header: event lines, peak bin, peak count, dropped count (all hex)
// event: phase (0 before start, 1 acquire, 2 after frameEnd), timestamp, repeat, gap cycles
4
6 0A 6 0
1 2A5 3 0
1 7C0 2 1
1 290 2 0
1 FFF 4 2
1 000 1 0
1 2BF 1 1
3 12 3 0
1 C40 3 0
1 480 3 1
1 100 2 0
2 0D 3FF 0
1 345 420 0
1 900 5 0
4 28 4 5
0 345 3 1
1 A00 4 0
1 340 2 1
2 345 5 0

// File: dv/sifhTb.sv
`timescale 1ns/1ns
`default_nettype none

module sifhTb;
    import sifhPkg::*;

    localparam int clkPeriod = 20;
    localparam int lcgEvents = 300;

    logic                 clk;
    logic                 res;
    logic                 start;
    logic                 frameEnd;
    logic                 tsValid;
    logic [tsWidth-1:0]   ts;
    logic                 acquire;
    logic                 busy;
    logic                 resultValid;
    peak_t                peak;
    logic [dropWidth-1:0] dropped;

    logic [15:0]          stim [0:127];  // words from the stim file
    int                   refHist [binNum];
    int                   watchCycles;
    int                   testsRun;
    int                   testsFailed;
    int                   checksFailed;
    int                   testErrors;
    int                   resultsSeen;
    int                   lastDrop;  // dropped count left over from the last frame
    bit                   inFrame;
    peak_t                gotPeak;
    logic [dropWidth-1:0] gotDropped;
    logic [31:0]          lcgState;

    sifhTop dut_i (
        .clk, .res, .start, .frameEnd, .tsValid, .ts,
        .acquire, .busy, .resultValid, .peak, .dropped
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        wait (watchCycles > 0);
        #(watchCycles * clkPeriod);
        $display("Timeout at %0t ns: simulation hung, no progress within %0d cycles",
                 $time, watchCycles);
        $display("Result: FAILED");
        $finish;
    end

    // outputs sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (inFrame && !busy) begin
            $display("Error at %0t ns: busy went low before resultValid", $time);
            testErrors++;
        end
        if (resultValid) begin
            gotPeak    = peak;
            gotDropped = dropped;
            resultsSeen++;
            inFrame    = 1'b0;
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #2;  // inputs change shortly after the edge
    endtask

    task automatic compareValue(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Mismatch at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic pulseEvents(input int tsVal, input int rep, input int gap);
        for (int i = 0; i < rep; i++) begin
            tsValid = 1'b1;
            ts      = tsWidth'(tsVal);
            nextCycle();
            tsValid = 1'b0;
            repeat (gap) nextCycle();
        end
    endtask

    task automatic sendPhase(input int first, input int nLines, input int phase, output int sent);
        int at;
        sent = 0;
        for (int i = 0; i < nLines; i++) begin
            at = first + 4 * i;
            if (stim[at] == phase) begin
                pulseEvents(stim[at + 1], stim[at + 2], stim[at + 3]);
                sent += stim[at + 2];
            end
        end
    endtask

    task automatic beginFrame();
        int cycles;
        cycles = 0;
        start  = 1'b1;
        nextCycle();  // start sampled at this edge
        start   = 1'b0;
        inFrame = 1'b1;
        while (!acquire && cycles < 4 * binNum) begin
            nextCycle();
            cycles++;
        end
        if (!acquire) begin
            $display("Error at %0t ns: acquire never rose after start", $time);
            testErrors++;
        end else begin
            compareValue("acquire latency", binNum + 2, cycles);
        end
        start = 1'b1;  // second start inside the frame
        nextCycle();
        start = 1'b0;
        if (!acquire) begin
            $display("Error at %0t ns: a start inside the frame ended acquisition", $time);
            testErrors++;
        end
    endtask

    task automatic endAndCheck(input int expBin, input int expCount, input int expDrop,
                               input int first, input int nLines);
        int seen;
        int cycles;
        int sent;
        seen     = resultsSeen;
        cycles   = 0;
        frameEnd = 1'b1;
        nextCycle();
        frameEnd = 1'b0;
        sendPhase(first, nLines, 2, sent);  // late strobes, must be dropped
        while (resultsSeen == seen && cycles < 8 * binNum) begin
            nextCycle();
            cycles++;
        end
        if (resultsSeen == seen) begin
            $display("Error at %0t ns: no resultValid after frameEnd", $time);
            testErrors++;
        end else begin
            compareValue("peak.bin", expBin, int'(gotPeak.bin));
            compareValue("peak.count", expCount, int'(gotPeak.count));
            compareValue("dropped", expDrop, int'(gotDropped));
        end
        lastDrop = expDrop;
    endtask

    task automatic closeTest(input string name);
        testsRun++;
        checksFailed += testErrors;
        if (testErrors == 0) begin
            $display("test %0d %s: ok", testsRun, name);
        end else begin
            $display("test %0d %s: %0d errors", testsRun, name, testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    task automatic runStimFrame(inout int pos, input string name);
        int nLines;
        int first;
        int preDrops;
        int sent;
        nLines = stim[pos];
        first  = pos + 4;
        sendPhase(first, nLines, 0, preDrops);  // strobes while idle
        nextCycle();
        compareValue("dropped before start", (lastDrop + preDrops > 255) ? 255 :
                     lastDrop + preDrops, int'(dropped));
        beginFrame();
        sendPhase(first, nLines, 1, sent);
        endAndCheck(stim[pos + 1], stim[pos + 2], stim[pos + 3], first, nLines);
        pos = first + 4 * nLines;
        closeTest(name);
    endtask

    task automatic runLcgFrame();
        logic [tsWidth-1:0] tsVal;
        int                 expBin;
        int                 expCount;
        for (int b = 0; b < binNum; b++) begin
            refHist[b] = 0;
        end
        beginFrame();
        for (int i = 0; i < lcgEvents; i++) begin
            lcgState = lcgNext(lcgState);
            tsVal    = lcgState[27:16];
            pulseEvents(tsVal, 1, (lcgState[31:30] == 2'b11) ? 1 : 0);
            refHist[tsVal[tsWidth-1 -: binBits]]++;  // bin is the coarse time
        end
        expBin   = 0;
        expCount = 0;
        for (int b = 0; b < binNum; b++) begin
            if (refHist[b] > expCount) begin  // first maximum wins
                expBin   = b;
                expCount = refHist[b];
            end
        end
        endAndCheck(expBin, (expCount > 1023) ? 1023 : expCount, 0, 0, 0);
        closeTest("random frame");
    endtask

    initial begin
        int nFrames;
        int pos;
        res          = 1'b0;
        start        = 1'b0;
        frameEnd     = 1'b0;
        tsValid      = 1'b0;
        ts           = '0;
        inFrame      = 1'b0;
        lastDrop     = 0;
        lcgState     = 32'd29778;
        $readmemh("dv/sifhStim.txt", stim);
        nFrames      = stim[0];
        watchCycles  = 200 * (nFrames + 1) + 2 * lcgEvents + 10;
        pos          = 1;
        for (int f = 0; f < nFrames; f++) begin
            for (int i = 0; i < stim[pos]; i++) begin
                watchCycles += stim[pos + 6 + 4 * i] * (1 + stim[pos + 7 + 4 * i]);
            end
            pos += 4 + 4 * stim[pos];
        end
        repeat (2) @(posedge clk);
        #2;
        res = 1'b1;
        if (nFrames == 0) begin
            $display("Error: no frames could be read from dv/sifhStim.txt");
            testErrors++;
        end
        compareValue("acquire", 0, acquire);
        compareValue("busy", 0, busy);
        compareValue("resultValid", 0, resultValid);
        compareValue("dropped", 0, int'(dropped));
        closeTest("reset state");
        pos = 1;
        for (int f = 0; f < nFrames; f++) begin
            runStimFrame(pos, $sformatf("stim frame %0d", f + 1));
        end
        runLcgFrame();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 testsRun, testsFailed, checksFailed);
        if (testsFailed == 0 && testErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module sifhTb -Mdir obj_dir -o sifhSim -f src.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sifhSim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

// File: source/binMapper.sv
`timescale 1ns/1ns
`default_nettype none

module binMapper (
    input  wire                           clk,
    input  wire                           res,
    input  wire                           tsValid,
    input  wire  [sifhPkg::tsWidth-1:0]   ts,
    input  wire                           acquire,
    input  wire                           frameStart,
    output sifhPkg::binInc_t              binInc,
    output logic [sifhPkg::dropWidth-1:0] dropped
);
    import sifhPkg::*;

    logic dropEvent;

    assign dropEvent = tsValid && !acquire;  // TDC strobe outside acquire phase

    // accepted strobe shows up as an increment one cycle later
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binInc <= '0;
        end else begin
            binInc.valid <= tsValid && acquire;
            binInc.bin   <= ts[tsWidth-1 -: binBits];  // coarse time picks the bin
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            dropped <= '0;
        end else if (frameStart) begin
            dropped <= '0;
        end else if (dropEvent && dropped != '1) begin
            dropped <= dropped + 1'b1;  // saturating
        end
    end

endmodule

`default_nettype wire

// File: source/histAccumulator.sv
`timescale 1ns/1ns
`default_nettype none

module histAccumulator (
    input  wire                           clk,
    input  wire                           res,
    input  wire sifhPkg::binInc_t         binInc,
    input  wire                           clearReq,
    input  wire                           drainReq,
    output sifhPkg::ramWr_t               ramWr,
    output sifhPkg::ramRd_t               ramRd,
    input  wire [sifhPkg::countWidth-1:0] rdData,
    output logic                          clearDone,
    output logic                          accIdle
);
    import sifhPkg::*;

    logic                  clearing;
    logic [binBits-1:0]    clrAddr;
    logic                  dValid;    // data stage
    logic [binBits-1:0]    dBin;
    ramWr_t                wStage;    // pending write
    ramWr_t                lastWr;    // write that landed at the last edge
    logic [countWidth-1:0] base;
    logic [countWidth-1:0] newCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clearing  <= 1'b0;
            clrAddr   <= '0;
            clearDone <= 1'b0;
        end else begin
            clearDone <= 1'b0;
            if (clearReq) begin
                clearing <= 1'b1;
                clrAddr  <= '0;
            end else if (clearing) begin
                clrAddr <= clrAddr + 1'b1;
                if (clrAddr == binNum - 1) begin
                    clearing  <= 1'b0;
                    clearDone <= 1'b1;  // one cycle after the last zero write
                end
            end
        end
    end

    // read stage
    assign ramRd.en   = binInc.valid && !clearing;
    assign ramRd.addr = binInc.bin;

    // data stage with forwarding, newest write first
    always_comb begin
        if (wStage.en && wStage.addr == dBin) begin
            base = wStage.data;
        end else if (lastWr.en && lastWr.addr == dBin) begin
            base = lastWr.data;  // RAM read raced this write
        end else begin
            base = rdData;
        end
        newCount = (base == countMax) ? base : base + 1'b1;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            dValid <= 1'b0;
            wStage <= '0;
            lastWr <= '0;
        end else begin
            dValid      <= ramRd.en;
            wStage.en   <= dValid;
            wStage.addr <= dBin;
            wStage.data <= newCount;
            lastWr      <= wStage;
        end
    end

    always_ff @(posedge clk) begin
        dBin <= binInc.bin;
    end

    // clear sweep owns the write port
    always_comb begin
        if (clearing) begin
            ramWr.en   = 1'b1;
            ramWr.addr = clrAddr;
            ramWr.data = '0;
        end else begin
            ramWr = wStage;
        end
    end

    assign accIdle = drainReq && !(binInc.valid || dValid || wStage.en);

endmodule

`default_nettype wire

// File: source/histRam.sv
`timescale 1ns/1ns
`default_nettype none

module histRam (
    input  wire                            clk,
    input  wire                            res,
    input  wire sifhPkg::ramWr_t           wr,
    input  wire sifhPkg::ramRd_t           rdA,
    input  wire sifhPkg::ramRd_t           rdB,
    output logic [sifhPkg::countWidth-1:0] dataA,
    output logic [sifhPkg::countWidth-1:0] dataB
);
    import sifhPkg::*;

    logic [countWidth-1:0] mem [binNum];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read data valid the cycle after the request
    // a read that hits the address being written returns the old count
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            dataA <= '0;
            dataB <= '0;
        end else begin
            if (rdA.en) begin
                dataA <= mem[rdA.addr];  // accumulator port
            end
            if (rdB.en) begin
                dataB <= mem[rdB.addr];  // peak finder port
            end
        end
    end

endmodule

`default_nettype wire

// File: source/peakFinder.sv
`timescale 1ns/1ns
`default_nettype none

module peakFinder (
    input  wire                           clk,
    input  wire                           res,
    input  wire                           scanReq,
    output sifhPkg::ramRd_t               ramRd,
    input  wire [sifhPkg::countWidth-1:0] rdData,
    output sifhPkg::peak_t                peak,
    output logic                          scanDone
);
    import sifhPkg::*;

    logic               scanning;
    logic [binBits-1:0] rdAddr;
    logic               cmpValid;
    logic [binBits-1:0] cmpBin;
    peak_t              best;
    peak_t              candidate;

    // bin 0 is read in the request cycle itself
    assign ramRd.en   = scanReq || scanning;
    assign ramRd.addr = scanning ? rdAddr : '0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning <= 1'b0;
            rdAddr   <= '0;
        end else if (scanReq) begin
            scanning <= 1'b1;
            rdAddr   <= binBits'(1);
        end else if (scanning) begin
            rdAddr <= rdAddr + 1'b1;
            if (rdAddr == binNum - 1) begin
                scanning <= 1'b0;
            end
        end
    end

    always_comb begin
        candidate = best;
        if (rdData > best.count) begin  // strict, lowest bin keeps a tie
            candidate.bin   = cmpBin;
            candidate.count = rdData;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cmpValid <= 1'b0;
            scanDone <= 1'b0;
            best     <= '0;
            peak     <= '0;
        end else begin
            cmpValid <= ramRd.en;
            scanDone <= 1'b0;
            if (scanReq) begin
                best <= '0;
            end else if (cmpValid) begin
                best <= candidate;
                if (cmpBin == binNum - 1) begin
                    peak     <= candidate;  // held until the next sweep ends
                    scanDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        cmpBin <= ramRd.addr;
    end

endmodule

`default_nettype wire

// File: source/sifhController.sv
`timescale 1ns/1ns
`default_nettype none

module sifhController (
    input  wire  clk,
    input  wire  res,
    input  wire  start,
    input  wire  frameEnd,
    input  wire  clearDone,
    input  wire  accIdle,
    input  wire  scanDone,
    output logic acquire,
    output logic busy,
    output logic clearReq,
    output logic drainReq,
    output logic scanReq,
    output logic resultValid,
    output logic frameStart
);
    import sifhPkg::*;

    phase_t state;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= phIdle;
            clearReq   <= 1'b0;
            scanReq    <= 1'b0;
            frameStart <= 1'b0;
        end else begin
            clearReq   <= 1'b0;
            scanReq    <= 1'b0;
            frameStart <= 1'b0;
            case (state)
                phIdle: begin
                    if (start) begin  // start elsewhere is ignored
                        state      <= phClear;
                        clearReq   <= 1'b1;
                        frameStart <= 1'b1;
                    end
                end
                phClear: begin
                    if (clearDone) begin
                        state <= phAcquire;
                    end
                end
                phAcquire: begin
                    if (frameEnd) begin
                        state <= phDrain;
                    end
                end
                phDrain: begin
                    if (accIdle) begin  // last increment written back
                        state   <= phScan;
                        scanReq <= 1'b1;
                    end
                end
                phScan: begin
                    if (scanDone) begin
                        state <= phReport;
                    end
                end
                default: state <= phIdle;  // report lasts one cycle
            endcase
        end
    end

    assign acquire     = state == phAcquire;
    assign busy        = state != phIdle;
    assign drainReq    = state == phDrain;
    assign resultValid = state == phReport;

endmodule

`default_nettype wire

// File: source/sifhPkg.sv
`default_nettype none

package sifhPkg;

    localparam int tsWidth    = 12;
    localparam int binBits    = 6;              // timestamp MSBs used as bin address
    localparam int binNum     = 1 << binBits;
    localparam int countWidth = 10;
    localparam int dropWidth  = 8;

    localparam logic [countWidth-1:0] countMax = '1;  // bin counts stop here

    // frame phases
    typedef enum logic [2:0] {
        phIdle,
        phClear,
        phAcquire,
        phDrain,
        phScan,
        phReport
    } phase_t;

    typedef struct packed {
        logic               valid;
        logic [binBits-1:0] bin;
    } binInc_t;

    typedef struct packed {
        logic                  en;
        logic [binBits-1:0]    addr;
        logic [countWidth-1:0] data;
    } ramWr_t;

    typedef struct packed {
        logic               en;
        logic [binBits-1:0] addr;
    } ramRd_t;

    typedef struct packed {
        logic [binBits-1:0]    bin;
        logic [countWidth-1:0] count;
    } peak_t;

endpackage

`default_nettype wire

// File: source/sifhTop.sv
`timescale 1ns/1ns
`default_nettype none

module sifhTop (
    input  wire                           clk,
    input  wire                           res,
    input  wire                           start,
    input  wire                           frameEnd,
    input  wire                           tsValid,
    input  wire  [sifhPkg::tsWidth-1:0]   ts,
    output logic                          acquire,
    output logic                          busy,
    output logic                          resultValid,
    output sifhPkg::peak_t                peak,
    output logic [sifhPkg::dropWidth-1:0] dropped
);
    import sifhPkg::*;

    binInc_t               binInc;
    ramWr_t                ramWr;
    ramRd_t                accRd;   // increment reads
    ramRd_t                scanRd;  // peak sweep reads
    logic [countWidth-1:0] accData;
    logic [countWidth-1:0] scanData;
    logic                  clearReq;
    logic                  clearDone;
    logic                  drainReq;
    logic                  accIdle;
    logic                  scanReq;
    logic                  scanDone;
    logic                  frameStart;

    sifhController ctrl_i (
        .clk, .res, .start, .frameEnd,
        .clearDone, .accIdle, .scanDone,
        .acquire, .busy, .clearReq, .drainReq,
        .scanReq, .resultValid, .frameStart
    );

    binMapper mapper_i (
        .clk, .res, .tsValid, .ts,
        .acquire, .frameStart, .binInc, .dropped
    );

    histAccumulator acc_i (
        .clk, .res, .binInc, .clearReq, .drainReq,
        .ramWr, .ramRd(accRd), .rdData(accData),
        .clearDone, .accIdle
    );

    histRam ram_i (
        .clk, .res, .wr(ramWr), .rdA(accRd), .rdB(scanRd),
        .dataA(accData), .dataB(scanData)
    );

    peakFinder peak_i (
        .clk, .res, .scanReq, .ramRd(scanRd),
        .rdData(scanData), .peak, .scanDone
    );

endmodule

`default_nettype wire

// File: src.f
source/sifhPkg.sv
source/binMapper.sv
source/histRam.sv
source/histAccumulator.sv
source/peakFinder.sv
source/sifhController.sv
source/sifhTop.sv
dv/histAccumulator_checker.sv
dv/sifhTb.sv
